// File: divSqrtUnit.f
common/divSqrtPkg.sv
common/iterIf.sv
divsqrt/divSqrtFsm.sv
divsqrt/stepCounter.sv
divsqrt/divSqrtIter.sv
logic/resultPost.sv
divSqrtUnit.sv
bench/divSqrtTb.sv

// File: bench/divSqrtTb.sv
`timescale 1ns/1ps
`default_nettype none

module divSqrtTb
  import divSqrtPkg::*;
();

  localparam int dataWidth = 16;
  localparam int numRandom = 40;
  localparam int numPow = 8;
  // Random ops of both kinds, power-of-two ops of both kinds, specials, stall and flush
  localparam int numOps = 2 * numRandom + 2 * numPow + 7;
  localparam int timeoutLimit = numOps * (dataWidth + 8) * 2;

  logic                 clk = 1'b0;
  logic                 arstN;
  logic                 start;
  opKind                op;
  logic [dataWidth-1:0] opA;
  logic [dataWidth-1:0] opB;
  logic                 stall;
  logic                 flush;
  logic                 busy;
  logic                 done;
  logic [dataWidth-1:0] result;
  logic [dataWidth-1:0] remainder;
  logic [31:0]          seed = 32'hc1f3;
  int                   cycleCount = 0;

  divSqrtUnit #(.dataWidth(dataWidth)) uut (
    .clk       (clk),
    .arstN     (arstN),
    .start     (start),
    .op        (op),
    .opA       (opA),
    .opB       (opB),
    .stall     (stall),
    .flush     (flush),
    .busy      (busy),
    .done      (done),
    .result    (result),
    .remainder (remainder)
  );

  always #10 clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  task automatic failRun(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [dataWidth-1:0] expected,
                            input logic [dataWidth-1:0] actual);
    assert (actual === expected) else
      failRun($sformatf("Error: %s expected %h actual %h", name, expected, actual));
  endtask

  task automatic checkCond(input bit ok, input string what);
    assert (ok) else failRun(what);
  endtask

  // Reference results straight from the arithmetic definitions
  task automatic modelOp(input opKind kind, input logic [dataWidth-1:0] a,
                         input logic [dataWidth-1:0] b, output logic [dataWidth-1:0] q,
                         output logic [dataWidth-1:0] r, output bit special);
    int root;
    root = 0;
    special = (a == '0);
    if (kind == opDiv) begin
      if (b == '0) begin
        q = '1;
        r = a;
        special = 1'b1;
      end else begin
        q = a / b;
        r = a % b;
      end
    end else begin
      // Largest root whose square still fits under the radicand
      while ((root + 1) * (root + 1) <= int'(a)) begin
        root++;
      end
      q = dataWidth'(root);
      r = dataWidth'(int'(a) - root * root);
    end
  endtask

  //////////////////////////////
  // One operation
  //////////////////////////////

  // Optionally holds stall over done and pokes start while busy or done
  task automatic runOp(input opKind kind, input logic [dataWidth-1:0] a,
                       input logic [dataWidth-1:0] b, input int stallCycles,
                       input bit pokeStart, input string name, output int waited);
    logic [dataWidth-1:0] expQ;
    logic [dataWidth-1:0] expR;
    bit                   special;
    int                   bound;
    modelOp(kind, a, b, expQ, expR, special);
    bound = special ? 0 : ((kind == opDiv) ? dataWidth : dataWidth / 2);
    @(posedge clk);
    start <= 1'b1;
    op    <= kind;
    opA   <= a;
    opB   <= b;
    @(negedge clk);
    checkCond(busy, {name, ": busy is low in the acceptance cycle"});
    // The unit samples start here and accepts it
    @(posedge clk);
    start <= pokeStart;
    opA   <= ~a;
    opB   <= ~b;
    stall <= (stallCycles > 0);
    @(negedge clk);
    waited = 0;
    while (!done) begin
      waited++;
      checkCond(busy, {name, ": busy dropped before done"});
      checkCond(waited <= bound, {name, ": done did not arrive within its cycle bound"});
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
    end
    // A start seen while done must not be taken
    checkCond(!busy, {name, ": busy is high while done"});
    checkValue({name, " result"}, expQ, result);
    checkValue({name, " remainder"}, expR, remainder);
    // A stalled done must hold both the flag and the values
    repeat (stallCycles) begin
      @(posedge clk);
      start <= pokeStart;
      @(negedge clk);
      checkCond(done, {name, ": done dropped while stall was high"});
      checkValue({name, " held result"}, expQ, result);
      checkValue({name, " held remainder"}, expR, remainder);
    end
    @(posedge clk);
    start <= 1'b0;
    stall <= 1'b0;
    if (stallCycles > 0) begin
      @(negedge clk);
      checkCond(done, {name, ": done dropped in the cycle stall was released"});
      checkValue({name, " held result"}, expQ, result);
      @(posedge clk);
    end
    @(negedge clk);
    checkCond(!done && !busy, {name, ": the unit did not return to idle"});
  endtask

  // Flush in the middle of a full-length divide
  task automatic flushOp(input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
    @(posedge clk);
    start <= 1'b1;
    op    <= opDiv;
    opA   <= a | dataWidth'(1);
    opB   <= b | dataWidth'(1);
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
    flush <= 1'b1;
    @(negedge clk);
    checkCond(busy && !done, "Flush test: the unit was not busy when flush rose");
    @(posedge clk);
    flush <= 1'b0;
    repeat (dataWidth + 2) begin
      @(negedge clk);
      checkCond(!done && !busy, "Flush test: the unit did not stay idle after flush");
    end
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= timeoutLimit) begin
      failRun("Timeout: the run went past its cycle limit");
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [31:0]          r;
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
    int                   waited;
    int                   stallCycles;
    int                   shiftA;
    int                   shiftB;
    arstN = 1'b0;
    start = 1'b0;
    op    = opDiv;
    opA   = '0;
    opB   = '0;
    stall = 1'b0;
    flush = 1'b0;
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    checkCond(!busy && !done, "Busy or done is high right after reset");

    // Random divides and square roots, some with stall and stray starts
    for (int i = 0; i < 2 * numRandom; i++) begin
      r = nextRand();
      a = r[31:16];
      r = nextRand();
      b = (r[31:16] == '0) ? dataWidth'(1) : r[31:16];
      stallCycles = (r[9:8] == 2'b11) ? int'(r[6:4]) : 0;
      if (i < numRandom) begin
        runOp(opDiv, a, b, stallCycles, r[2], "random div", waited);
      end else begin
        runOp(opSqrt, a, b, stallCycles, r[2], "random sqrt", waited);
      end
    end

    // Special cases finish one cycle after acceptance
    r = nextRand();
    runOp(opDiv, r[31:16] | dataWidth'(1), '0, 0, 1'b0, "div by zero", waited);
    runOp(opDiv, '0, '0, 2, 1'b1, "zero by zero", waited);
    runOp(opDiv, '0, r[15:0] | dataWidth'(1), 0, 1'b0, "zero dividend", waited);
    runOp(opSqrt, '0, r[15:0], 0, 1'b1, "zero radicand", waited);

    // Powers of two leave only zero bits behind and stop early
    for (int i = 0; i < numPow; i++) begin
      r = nextRand();
      shiftA = 1 + int'(r[19:16]) % (dataWidth - 1);
      shiftB = int'(r[27:24]) % shiftA;
      a = dataWidth'(1) << shiftA;
      b = dataWidth'(1) << shiftB;
      runOp(opDiv, a, b, 0, 1'b0, "pow2 div", waited);
      checkCond(waited < dataWidth, "Power-of-two divide did not terminate early");
      shiftA = 1 + int'(r[11:8]) % (dataWidth / 2 - 1);
      a = dataWidth'(1) << (2 * shiftA);
      runOp(opSqrt, a, '0, 0, 1'b0, "pow4 sqrt", waited);
      checkCond(waited < dataWidth / 2, "Power-of-four square root did not terminate early");
    end

    // Long stall with stray starts, then a flush and a clean operation after it
    r = nextRand();
    runOp(opDiv, r[31:16], r[15:0] | dataWidth'(1), 6, 1'b1, "stalled div", waited);
    flushOp(r[31:16], r[15:0]);
    runOp(opSqrt, r[31:16], '0, 0, 1'b0, "sqrt after flush", waited);

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: divSqrtUnit.sv
`timescale 1ns/1ps
`default_nettype none

module divSqrtUnit
  import divSqrtPkg::*;
#(
  parameter int dataWidth = 16
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 start,
  input  opKind                op,
  input  logic [dataWidth-1:0] opA,
  input  logic [dataWidth-1:0] opB,
  input  logic                 stall,
  input  logic                 flush,
  output logic                 busy,
  output logic                 done,
  output logic [dataWidth-1:0] result,
  output logic [dataWidth-1:0] remainder
);

  logic                 specialCase;
  logic [1:0]           specialKind;
  logic [dataWidth-1:0] partRem;
  logic [dataWidth-1:0] partRes;

  // Iteration controls shared by the state machine, counter, datapath and post block
  iterIf #(.dataWidth(dataWidth)) ctl ();

  divSqrtFsm #(.dataWidth(dataWidth)) fsm (
    .clk         (clk),
    .arstN       (arstN),
    .start       (start),
    .op          (op),
    .opA         (opA),
    .opB         (opB),
    .stall       (stall),
    .flush       (flush),
    .ctl         (ctl.fsmPort),
    .busy        (busy),
    .done        (done),
    .specialCase (specialCase),
    .specialKind (specialKind)
  );

  stepCounter #(.dataWidth(dataWidth)) counter (
    .clk   (clk),
    .arstN (arstN),
    .op    (op),
    .ctl   (ctl.counterPort)
  );

  divSqrtIter #(.dataWidth(dataWidth)) iter (
    .clk     (clk),
    .arstN   (arstN),
    .op      (op),
    .opA     (opA),
    .opB     (opB),
    .dp      (ctl.iterPort),
    .partRem (partRem),
    .partRes (partRes)
  );

  resultPost #(.dataWidth(dataWidth)) postProc (
    .clk         (clk),
    .arstN       (arstN),
    .op          (op),
    .opA         (opA),
    .done        (done),
    .specialCase (specialCase),
    .specialKind (specialKind),
    .post        (ctl.postPort),
    .partRem     (partRem),
    .partRes     (partRes),
    .result      (result),
    .remainder   (remainder)
  );

endmodule

`default_nettype wire

// File: logic/resultPost.sv
`timescale 1ns/1ps
`default_nettype none

module resultPost
  import divSqrtPkg::*;
#(
  parameter int dataWidth = 16
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  opKind                op,
  input  logic [dataWidth-1:0] opA,
  input  logic                 done,
  input  logic                 specialCase,
  input  logic [1:0]           specialKind,
  iterIf.postPort              post,
  input  logic [dataWidth-1:0] partRem,
  input  logic [dataWidth-1:0] partRes,
  output logic [dataWidth-1:0] result,
  output logic [dataWidth-1:0] remainder
);

  localparam int stepWidth = $clog2(dataWidth + 1);

  logic [stepWidth-1:0] shiftAmt;
  logic [dataWidth-1:0] normalRes;
  logic                 isDivZero;

  //////////////////////////////
  // Early termination
  //////////////////////////////

  // The current step is counted in remaining, so one less is still owed
  // Skipped steps would only have appended zero bits
  assign shiftAmt  = post.residualZero ? post.remaining - stepWidth'(1) : '0;
  assign normalRes = partRes << shiftAmt;

  // Only a divide can hit divide by zero
  assign isDivZero = (op == opDiv) && (specialKind == kindDivZero);

  //////////////////////////////
  // Output registers
  //////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      result    <= '0;
      remainder <= '0;
    end else if (specialCase) begin
      // Captured in the acceptance cycle while the operands are still valid
      // Divide by zero returns all ones and passes the dividend through
      result    <= isDivZero ? '1 : '0;
      remainder <= isDivZero ? opA : '0;
    end else if (!done) begin
      // Tracks every step, so the edge into done leaves the final value
      result    <= normalRes;
      remainder <= partRem;
    end
  end

endmodule

`default_nettype wire

// File: divsqrt/divSqrtIter.sv
`timescale 1ns/1ps
`default_nettype none

module divSqrtIter
  import divSqrtPkg::*;
#(
  parameter int dataWidth = 16
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  opKind                op,
  input  logic [dataWidth-1:0] opA,
  input  logic [dataWidth-1:0] opB,
  iterIf.iterPort              dp,
  output logic [dataWidth-1:0] partRem,
  output logic [dataWidth-1:0] partRes
);

  // Square root brings down two bits per step, hence two spare bits
  localparam int remWidth = dataWidth + 2;

  opKind                opQ;
  logic [remWidth-1:0]  rem;
  logic [dataWidth-1:0] src;
  logic [dataWidth-1:0] divisor;
  logic [dataWidth-1:0] res;

  logic [remWidth-1:0]  shifted;
  logic [remWidth-1:0]  subtrahend;
  logic [remWidth:0]    trial;
  logic                 resBit;
  logic [remWidth-1:0]  remNext;
  logic [dataWidth-1:0] srcNext;
  logic [dataWidth-1:0] resNext;

  //////////////////////////////
  // One recurrence step
  //////////////////////////////

  always_comb begin
    if (opQ == opDiv) begin
      // Bring down the next dividend bit and compare with the divisor
      shifted    = {1'b0, rem[dataWidth-1:0], src[dataWidth-1]};
      subtrahend = {2'b00, divisor};
      srcNext    = {src[dataWidth-2:0], 1'b0};
    end else begin
      // Bring down two radicand bits and compare with 4 * root + 1
      shifted    = {rem[dataWidth-1:0], src[dataWidth-1:dataWidth-2]};
      subtrahend = {res, 2'b01};
      srcNext    = {src[dataWidth-3:0], 2'b00};
    end
    trial = {1'b0, shifted} - {1'b0, subtrahend};
    // A clear borrow means the trial subtraction fits
    resBit  = !trial[remWidth];
    remNext = resBit ? trial[remWidth-1:0] : shifted;
    resNext = {res[dataWidth-2:0], resBit};
  end

  // Zero residual with only zero bits left to bring down
  // Every later step would append a zero bit and keep the residual zero
  assign dp.residualZero = (remNext == '0) && (srcNext == '0);

  // Post block sees the values this step produces
  assign partRem = remNext[dataWidth-1:0];
  assign partRes = resNext;

  //////////////////////////////
  // Registers
  //////////////////////////////

  // The operation has to outlive the start cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      opQ <= opDiv;
    end else if (dp.load) begin
      opQ <= op;
    end
  end

  always_ff @(posedge clk) begin
    if (dp.load) begin
      rem     <= '0;
      res     <= '0;
      src     <= opA;
      divisor <= opB;
    end else if (dp.iterate) begin
      rem <= remNext;
      res <= resNext;
      src <= srcNext;
    end
  end

endmodule

`default_nettype wire

// File: divsqrt/stepCounter.sv
`timescale 1ns/1ps
`default_nettype none

module stepCounter
  import divSqrtPkg::*;
#(
  parameter int dataWidth = 16
) (
  input  logic       clk,
  input  logic       arstN,
  input  opKind      op,
  iterIf.counterPort ctl
);

  localparam int stepWidth = $clog2(dataWidth + 1);

  logic [stepWidth-1:0] count;
  logic [stepWidth-1:0] stepsForOp;

  // Divide retires one dividend bit per step, square root two radicand bits
  assign stepsForOp = (op == opDiv) ? stepWidth'(dataWidth) : stepWidth'(dataWidth / 2);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      count <= '0;
    end else if (ctl.load) begin
      count <= stepsForOp;
    end else if (ctl.iterate && (count != '0)) begin
      // Never wraps, so the post block always sees a sane count
      count <= count - stepWidth'(1);
    end
  end

  // One step left means the current busy cycle is the final one
  assign ctl.lastStep  = (count == stepWidth'(1));
  assign ctl.remaining = count;

endmodule

`default_nettype wire

// File: divsqrt/divSqrtFsm.sv
`timescale 1ns/1ps
`default_nettype none

module divSqrtFsm
  import divSqrtPkg::*;
#(
  parameter int dataWidth = 16
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 start,
  input  opKind                op,
  input  logic [dataWidth-1:0] opA,
  input  logic [dataWidth-1:0] opB,
  input  logic                 stall,
  input  logic                 flush,
  iterIf.fsmPort               ctl,
  output logic                 busy,
  output logic                 done,
  output logic                 specialCase,
  output logic [1:0]           specialKind
);

  fsmState state;
  fsmState stateNext;
  logic    accept;
  logic    divZero;
  logic    zeroOperand;

  //////////////////////////////
  // Start gating
  //////////////////////////////

  // A start only counts in idle and while downstream is not stalled
  assign accept = start && (state == stIdle) && !stall;

  // Operands are only valid in the start cycle, so detection is done there
  assign divZero     = (op == opDiv) && (opB == '0);
  assign zeroOperand = (opA == '0);

  // Divide by zero wins over a zero dividend
  always_comb begin
    specialKind = kindNone;
    if (divZero) begin
      specialKind = kindDivZero;
    end else if (zeroOperand) begin
      specialKind = kindZero;
    end
  end

  // The post block latches its special result in the acceptance cycle
  assign specialCase = accept && (specialKind != kindNone);

  // Only a normal start kicks off the counter and the datapath
  assign ctl.load    = accept && (specialKind == kindNone);
  assign ctl.iterate = (state == stBusy);

  // Busy covers the acceptance cycle as well as the busy state
  assign busy = accept || (state == stBusy);
  assign done = (state == stDone);

  //////////////////////////////
  // State transitions
  //////////////////////////////

  always_comb begin
    stateNext = state;
    case (state)
      stIdle: begin
        if (accept) begin
          stateNext = specialCase ? stDone : stBusy;
        end
      end
      stBusy: begin
        // Out of steps, or nothing left that could change the result
        if (ctl.lastStep || ctl.residualZero) begin
          stateNext = stDone;
        end
      end
      stDone: begin
        // Done is held for as long as downstream stalls
        if (!stall) begin
          stateNext = stIdle;
        end
      end
      default: stateNext = stIdle;
    endcase
    // Flush overrides everything else
    if (flush) begin
      stateNext = stIdle;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stIdle;
    end else begin
      state <= stateNext;
    end
  end

endmodule

`default_nettype wire

// File: common/iterIf.sv
`timescale 1ns/1ps
`default_nettype none

interface iterIf #(
  parameter int dataWidth = 16
);

  // Wide enough to hold the full divide step count
  localparam int stepWidth = $clog2(dataWidth + 1);

  logic                 load;
  logic                 iterate;
  logic                 lastStep;
  logic [stepWidth-1:0] remaining;
  logic                 residualZero;

  // The state machine steers and the counter and datapath follow
  modport fsmPort (
    output load,
    output iterate,
    input  lastStep,
    input  residualZero
  );

  modport counterPort (
    input  load,
    input  iterate,
    output lastStep,
    output remaining
  );

  modport iterPort (
    input  load,
    input  iterate,
    output residualZero
  );

  // The post block only observes and never drives anything here
  modport postPort (
    input remaining,
    input residualZero
  );

endinterface

`default_nettype wire

// File: common/divSqrtPkg.sv
`default_nettype none

package divSqrtPkg;

  ////////////////////////////////
  // Operation and state encodings
  ////////////////////////////////

  // Selects between the divide and the square root recurrence
  typedef enum logic {
    opDiv,
    opSqrt
  } opKind;

  // Top-level control states of the unit
  typedef enum logic [1:0] {
    stIdle,
    stBusy,
    stDone
  } fsmState;

  // Special-case kinds passed from the state machine to the post block
  // A zero dividend with a zero divisor is reported as divide by zero
  localparam logic [1:0] kindNone    = 2'b00;
  localparam logic [1:0] kindDivZero = 2'b01;
  localparam logic [1:0] kindZero    = 2'b10;

endpackage

`default_nettype wire
